/* hw/daq_pkg.sv */
`default_nettype none

package daq_pkg;

    // bus and fifo word width.
    localparam int data_width = 32;

    // register bus address width.
    localparam int addr_width = 32;

    // width of the output port.
    localparam int gpio_width = 8;

    // register map.
    localparam logic [addr_width-1:0] gpio_addr = 32'h1000;
    localparam logic [addr_width-1:0] count_addr = 32'h1004;

    // output buffer size in words.
    localparam int fifo_depth = 16;

    // fill count must hold the value fifo_depth itself.
    localparam int fifo_cnt_width = 5;

    // register hit by a bus access.
    typedef enum logic [1:0] {
        sel_none  = 2'd0,
        sel_gpio  = 2'd1,
        sel_count = 2'd2
    } reg_sel_e;

endpackage

`default_nettype wire

/* hw/daq_bus_if.sv */
`default_nettype none

interface daq_bus_if;

    // the register select arrives already decoded from the address.
    daq_pkg::reg_sel_e sel;
    logic [daq_pkg::data_width-1:0] wdata;
    logic [daq_pkg::data_width-1:0] rdata;

    // single-cycle strobes that only act together with sel.
    logic rd;
    logic wr;

    modport master (
        output sel,
        output wdata,
        output rd,
        output wr,
        input  rdata
    );

    modport regs (
        input  sel,
        input  wdata,
        input  rd,
        input  wr,
        output rdata
    );

endinterface

`default_nettype wire

/* hw/gpio_regs.sv */
`default_nettype none

module gpio_regs (
    input wire                              BUS_CLK,
    input wire                              rst_n,
    input wire [daq_pkg::data_width-1:0]    count,
    daq_bus_if.regs                         bus,
    output logic [daq_pkg::gpio_width-1:0]  gpio
);

    logic [daq_pkg::gpio_width-1:0] gpio_q;
    logic [daq_pkg::data_width-1:0] rdata_q;
    logic [daq_pkg::data_width-1:0] gpio_ext;

    // gpio value as a full bus word.
    assign gpio_ext = {{(daq_pkg::data_width - daq_pkg::gpio_width){1'b0}}, gpio_q};

    // only a gpio write changes the output register.
    always_ff @(posedge BUS_CLK or negedge rst_n) begin
        if (!rst_n) begin
            gpio_q <= '0;
        end else if (bus.wr && (bus.sel == daq_pkg::sel_gpio)) begin
            gpio_q <= bus.wdata[daq_pkg::gpio_width-1:0];
        end
    end

    // read data is captured on the strobe and held until the next read.
    always_ff @(posedge BUS_CLK or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (bus.rd) begin
            case (bus.sel)
                daq_pkg::sel_gpio: begin
                    rdata_q <= gpio_ext;
                end
                daq_pkg::sel_count: begin
                    rdata_q <= count;
                end
                default: begin
                    rdata_q <= '0;
                end
            endcase
        end
    end

    assign gpio = gpio_q;
    assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

/* hw/count_source.sv */
`default_nettype none

module count_source (
    input wire                              BUS_CLK,
    input wire                              rst_n,
    input wire                              next,
    input wire                              afull,
    output logic                            fifo_wr,
    output logic [daq_pkg::data_width-1:0]  fifo_wdata,
    output logic [daq_pkg::data_width-1:0]  count
);

    logic [daq_pkg::data_width-1:0] count_q;
    logic [daq_pkg::data_width-1:0] wdata_q;
    logic                           wr_q;

    // pattern counter and write strobe.
    // the count holds while the fifo has no room and clears when next drops.
    always_ff @(posedge BUS_CLK or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
            wr_q    <= 1'b0;
        end else if (!next) begin
            count_q <= '0;
            wr_q    <= 1'b0;
        end else if (!afull) begin
            count_q <= count_q + 1'b1;
            wr_q    <= 1'b1;
        end else begin
            wr_q    <= 1'b0;
        end
    end

    // data word travels with the strobe.
    always_ff @(posedge BUS_CLK) begin
        if (next && !afull) begin
            wdata_q <= count_q;
        end
    end

    assign fifo_wr    = wr_q;
    assign fifo_wdata = wdata_q;
    assign count      = count_q;

    // a full buffer must stop the very next write.
    a_no_wr_after_afull: assert property (
        @(posedge BUS_CLK) disable iff (!rst_n) afull |=> !fifo_wr
    );

endmodule

`default_nettype wire

/* hw/data_fifo.sv */
`default_nettype none

module data_fifo (
    input wire                              BUS_CLK,
    input wire                              rst_n,
    input wire                              wr,
    input wire [daq_pkg::data_width-1:0]    wdata,
    input wire                              pop,
    output logic [daq_pkg::data_width-1:0]  rdata,
    output logic                            empty,
    output logic                            afull
);

    logic [daq_pkg::data_width-1:0] mem [daq_pkg::fifo_depth];

    logic [$clog2(daq_pkg::fifo_depth)-1:0] wr_ptr;
    logic [$clog2(daq_pkg::fifo_depth)-1:0] rd_ptr;
    logic [daq_pkg::fifo_cnt_width-1:0]     cnt;

    logic do_push;
    logic do_pop;

    assign do_push = wr && (cnt != daq_pkg::fifo_depth);
    // pop on an empty buffer is dropped.
    assign do_pop  = pop && (cnt != '0);

    always_ff @(posedge BUS_CLK) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge BUS_CLK or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: begin
                    cnt <= cnt + 1'b1;
                end
                2'b01: begin
                    cnt <= cnt - 1'b1;
                end
                default: begin
                    cnt <= cnt;
                end
            endcase
        end
    end

    // the head word falls through to the read port.
    assign rdata = mem[rd_ptr];
    assign empty = (cnt == '0);

    // the write in flight counts as stored, so one word stays in reserve.
    assign afull = (cnt + wr) >= (daq_pkg::fifo_depth - 1);

    // the source has to respect afull, so a full buffer never sees a write.
    a_no_wr_when_full: assert property (
        @(posedge BUS_CLK) disable iff (!rst_n) wr |-> (cnt < daq_pkg::fifo_depth)
    );

endmodule

`default_nettype wire

/* hw/daq_core.sv */
`default_nettype none

module daq_core (
    input wire                              BUS_CLK,
    input wire                              rst_n,
    input wire [daq_pkg::addr_width-1:0]    bus_addr,
    input wire [daq_pkg::data_width-1:0]    bus_wdata,
    input wire                              bus_rd,
    input wire                              bus_wr,
    input wire                              next,
    input wire                              afull,
    output logic [daq_pkg::data_width-1:0]  bus_rdata,
    output logic [daq_pkg::gpio_width-1:0]  gpio,
    output logic                            fifo_wr,
    output logic [daq_pkg::data_width-1:0]  fifo_wdata
);

    daq_bus_if bus_if ();

    daq_pkg::reg_sel_e              sel;
    logic [daq_pkg::data_width-1:0] count;

    // only a full address match selects a register.
    always_comb begin
        case (bus_addr)
            daq_pkg::gpio_addr:  sel = daq_pkg::sel_gpio;
            daq_pkg::count_addr: sel = daq_pkg::sel_count;
            default:             sel = daq_pkg::sel_none;
        endcase
    end

    // master side of the register bus.
    assign bus_if.sel   = sel;
    assign bus_if.wdata = bus_wdata;
    assign bus_if.rd    = bus_rd;
    assign bus_if.wr    = bus_wr;
    assign bus_rdata    = bus_if.rdata;

    gpio_regs u_gpio_regs (
        .BUS_CLK (BUS_CLK),
        .rst_n   (rst_n),
        .count   (count),
        .bus     (bus_if.regs),
        .gpio    (gpio)
    );

    count_source u_count_source (
        .BUS_CLK    (BUS_CLK),
        .rst_n      (rst_n),
        .next       (next),
        .afull      (afull),
        .fifo_wr    (fifo_wr),
        .fifo_wdata (fifo_wdata),
        .count      (count)
    );

    a_rd_wr_exclusive: assert property (
        @(posedge BUS_CLK) disable iff (!rst_n) !(bus_rd && bus_wr)
    );

endmodule

`default_nettype wire

/* hw/daq_top.sv */
`default_nettype none

module daq_top (
    input wire                              BUS_CLK,
    input wire                              rst_n,
    input wire [daq_pkg::addr_width-1:0]    bus_addr,
    input wire [daq_pkg::data_width-1:0]    bus_wdata,
    input wire                              bus_rd,
    input wire                              bus_wr,
    input wire                              next,
    input wire                              pop,
    output logic [daq_pkg::data_width-1:0]  bus_rdata,
    output logic [daq_pkg::gpio_width-1:0]  gpio,
    output logic                            fifo_empty,
    output logic [daq_pkg::data_width-1:0]  fifo_data
);

    logic                           fifo_wr;
    logic [daq_pkg::data_width-1:0] fifo_wdata;
    logic                           afull;

    daq_core u_daq_core (
        .BUS_CLK    (BUS_CLK),
        .rst_n      (rst_n),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_rd     (bus_rd),
        .bus_wr     (bus_wr),
        .next       (next),
        .afull      (afull),
        .bus_rdata  (bus_rdata),
        .gpio       (gpio),
        .fifo_wr    (fifo_wr),
        .fifo_wdata (fifo_wdata)
    );

    // afull goes back to the source for back-pressure.
    data_fifo u_data_fifo (
        .BUS_CLK (BUS_CLK),
        .rst_n   (rst_n),
        .wr      (fifo_wr),
        .wdata   (fifo_wdata),
        .pop     (pop),
        .rdata   (fifo_data),
        .empty   (fifo_empty),
        .afull   (afull)
    );

endmodule

`default_nettype wire

/* tb/tb_daq.sv */
`default_nettype none

module tb_daq;

    timeunit 1ns;
    timeprecision 1ps;

    logic                              BUS_CLK;
    logic                              rst_n;
    logic [daq_pkg::addr_width-1:0]    bus_addr;
    logic [daq_pkg::data_width-1:0]    bus_wdata;
    logic                              bus_rd;
    logic                              bus_wr;
    logic                              next;
    logic                              pop;
    logic [daq_pkg::data_width-1:0]    bus_rdata;
    logic [daq_pkg::gpio_width-1:0]    gpio;
    logic                              fifo_empty;
    logic [daq_pkg::data_width-1:0]    fifo_data;

    integer seed;

    daq_top dut0 (
        .BUS_CLK    (BUS_CLK),
        .rst_n      (rst_n),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_rd     (bus_rd),
        .bus_wr     (bus_wr),
        .next       (next),
        .pop        (pop),
        .bus_rdata  (bus_rdata),
        .gpio       (gpio),
        .fifo_empty (fifo_empty),
        .fifo_data  (fifo_data)
    );

    // 40 ns bus clock.
    always #20 BUS_CLK = ~BUS_CLK;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [daq_pkg::data_width-1:0] got,
                              input logic [daq_pkg::data_width-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_gpio(input string name, input logic [daq_pkg::gpio_width-1:0] got,
                              input logic [daq_pkg::gpio_width-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // bus tasks start and end on a falling edge.
    task automatic bus_write(input logic [daq_pkg::addr_width-1:0] addr,
                             input logic [daq_pkg::data_width-1:0] data);
        bus_addr  = addr;
        bus_wdata = data;
        bus_wr    = 1'b1;
        @(negedge BUS_CLK);
        bus_wr    = 1'b0;
    endtask

    task automatic bus_read(input logic [daq_pkg::addr_width-1:0] addr,
                            output logic [daq_pkg::data_width-1:0] data);
        bus_addr = addr;
        bus_rd   = 1'b1;
        @(negedge BUS_CLK);
        bus_rd   = 1'b0;
        data     = bus_rdata;
    endtask

    task automatic wait_not_empty();
        int waited;
        waited = 0;
        while (fifo_empty) begin
            if (waited == 50) begin
                abort_run("timeout: the fifo stayed empty for 50 cycles");
            end
            @(negedge BUS_CLK);
            waited++;
        end
    endtask

    task automatic pop_word(output logic [daq_pkg::data_width-1:0] data);
        wait_not_empty();
        data = fifo_data;
        pop  = 1'b1;
        @(negedge BUS_CLK);
        pop  = 1'b0;
    endtask

    task automatic pop_expect(input logic [daq_pkg::data_width-1:0] exp);
        logic [daq_pkg::data_width-1:0] got;
        pop_word(got);
        check_word("fifo_data", got, exp);
    endtask

    task automatic reset_values();
        logic [daq_pkg::data_width-1:0] rdata;
        check_gpio("gpio", gpio, '0);
        check_flag("fifo_empty", fifo_empty, 1'b1);
        check_word("bus_rdata", bus_rdata, '0);
        bus_read(daq_pkg::count_addr, rdata);
        check_word("bus_rdata", rdata, '0);
    endtask

    task automatic gpio_access();
        logic [daq_pkg::data_width-1:0] wdata;
        logic [daq_pkg::data_width-1:0] rdata;
        logic [daq_pkg::gpio_width-1:0] expected;
        int i;
        for (i = 0; i < 8; i++) begin
            wdata    = $random(seed);
            expected = wdata[daq_pkg::gpio_width-1:0];
            bus_write(daq_pkg::gpio_addr, wdata);
            check_gpio("gpio", gpio, expected);
            bus_read(daq_pkg::gpio_addr, rdata);
            check_word("bus_rdata", rdata, {24'h0, expected});
        end
        // count register and unmapped space must not touch the output.
        bus_write(daq_pkg::count_addr, ~wdata);
        check_gpio("gpio", gpio, expected);
        bus_write(32'h0000_1008, 32'hffff_ffff);
        check_gpio("gpio", gpio, expected);
        // leave a nonzero word on the read bus before the unmapped read.
        bus_write(daq_pkg::gpio_addr, 32'h0000_005a);
        bus_read(daq_pkg::gpio_addr, rdata);
        check_word("bus_rdata", rdata, 32'h0000_005a);
        bus_read(32'h0000_2000, rdata);
        check_word("bus_rdata", rdata, '0);
    endtask

    task automatic short_burst();
        int i;
        next = 1'b1;
        repeat (5) @(negedge BUS_CLK);
        next = 1'b0;
        for (i = 0; i < 5; i++) begin
            pop_expect(i);
        end
        check_flag("fifo_empty", fifo_empty, 1'b1);
        repeat (2) @(negedge BUS_CLK);
        check_flag("fifo_empty", fifo_empty, 1'b1);
    endtask

    task automatic backpressure();
        logic [daq_pkg::data_width-1:0] rdata;
        int reads;
        int i;
        reads = 0;
        rdata = '0;
        next  = 1'b1;
        // one word stays in reserve, so the source stops one short of the depth.
        while (rdata < daq_pkg::fifo_depth - 1) begin
            if (reads == 50) begin
                abort_run("timeout: the source count never reached the stall point");
            end
            bus_read(daq_pkg::count_addr, rdata);
            reads++;
        end
        check_word("bus_rdata", rdata, daq_pkg::fifo_depth - 1);
        repeat (4) @(negedge BUS_CLK);
        bus_read(daq_pkg::count_addr, rdata);
        check_word("bus_rdata", rdata, daq_pkg::fifo_depth - 1);
        next = 1'b0;
        @(negedge BUS_CLK);
        for (i = 0; i < daq_pkg::fifo_depth - 1; i++) begin
            pop_expect(i);
        end
        check_flag("fifo_empty", fifo_empty, 1'b1);
        repeat (2) @(negedge BUS_CLK);
        check_flag("fifo_empty", fifo_empty, 1'b1);
    endtask

    task automatic count_readback();
        logic [daq_pkg::data_width-1:0] seen;
        logic [daq_pkg::data_width-1:0] rdata;
        logic [daq_pkg::data_width-1:0] word;
        int popped;
        popped = 0;
        next   = 1'b1;
        wait_not_empty();
        bus_read(daq_pkg::count_addr, seen);
        next = 1'b0;
        // let the last word land.
        @(negedge BUS_CLK);
        while (!fifo_empty && popped < daq_pkg::fifo_depth) begin
            pop_word(word);
            check_word("fifo_data", word, popped);
            popped++;
        end
        // the word sent on the read edge carries the value read, so it is not yet counted.
        check_word("bus_rdata", seen, popped - 1);
        bus_read(daq_pkg::count_addr, rdata);
        check_word("bus_rdata", rdata, '0);
    endtask

    initial begin
        seed      = 32'hf445_c0ee;
        BUS_CLK   = 1'b0;
        rst_n     = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        bus_rd    = 1'b0;
        bus_wr    = 1'b0;
        next      = 1'b0;
        pop       = 1'b0;
        repeat (4) @(posedge BUS_CLK);
        @(negedge BUS_CLK);
        rst_n = 1'b1;
        @(negedge BUS_CLK);
        reset_values();
        gpio_access();
        short_burst();
        backpressure();
        count_readback();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
hw/daq_pkg.sv
hw/daq_bus_if.sv
hw/gpio_regs.sv
hw/count_source.sv
hw/data_fifo.sv
hw/daq_core.sv
hw/daq_top.sv
tb/tb_daq.sv

/* Bender.yml */
package:
  name: daq

sources:
  - files:
      - hw/daq_pkg.sv
      - hw/daq_bus_if.sv
      - hw/gpio_regs.sv
      - hw/count_source.sv
      - hw/data_fifo.sv
      - hw/daq_core.sv
      - hw/daq_top.sv
  - target: test
    files:
      - tb/tb_daq.sv
